// ==== cache_config.svh ====
////////////////////////////////////////////////////////////
// widths and sizes of the direct-mapped read cache
// included by the package and by every module that sizes
// an array or slices a CPU byte address
////////////////////////////////////////////////////////////

`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// address layout is tag[31:9] index[8:4] word[3:1] byte[0]
`define CACHE_ADDR_W		32		// CPU byte address width
`define CACHE_DATA_W		16		// CPU and memory data word width

`define CACHE_TAG_W		23		// upper address bits kept per line
`define CACHE_INDEX_W		5		// selects one of the cache lines
`define CACHE_WORD_SEL_W	3		// selects one word inside a line

// geometry, which must agree with the field widths above
`define CACHE_LINES		32		// 2 ** CACHE_INDEX_W lines
`define CACHE_LINE_WORDS	8		// 2 ** CACHE_WORD_SEL_W words per line

`endif

// ==== cachePkg.sv ====
////////////////////////////////////////////////////////////
// shared types of the cache controller
// vector typedefs for the address fields, the CPU and
// memory request structs and the sequencer state encoding
////////////////////////////////////////////////////////////

`default_nettype none

`include "cache_config.svh"

package cachePkg;

	typedef logic [`CACHE_ADDR_W-1:0]	addrT;		// CPU byte address
	typedef logic [`CACHE_DATA_W-1:0]	dataT;		// one 16 bit data word
	typedef logic [`CACHE_TAG_W-1:0]	tagT;		// address bits 31 to 9
	typedef logic [`CACHE_INDEX_W-1:0]	indexT;		// address bits 8 to 4
	typedef logic [`CACHE_WORD_SEL_W-1:0]	wordSelT;	// address bits 3 to 1
	typedef logic [1:0]			byteEnT;	// bit 1 upper lane, bit 0 lower lane

	// request from the CPU, held stable while CpuReq is high
	typedef struct packed {
		addrT	address;	// byte address, bit 0 ignored by the cache
		dataT	writeData;	// data for a write
		logic	write;		// high for a write, low for a read
		byteEnT	byteEn;		// active high byte lanes
	} cpuReqT;

	// request to memory, held stable while MemReq is high
	typedef struct packed {
		addrT	address;	// full address on writes, line word on fills
		dataT	writeData;	// data for a write
		logic	write;		// high for a write, low for a fill read
		byteEnT	byteEn;		// both lanes set on fill reads
	} memReqT;

	// sequencer states
	typedef enum logic [2:0] {
		Invalidate,	// clearing valid bits after reset
		Idle,		// waiting for a CPU request
		Lookup,		// tag compare result is available
		Fill,		// reading a whole line from memory
		ReadDone,	// read data returned, waiting for CpuReq to fall
		WriteMem,	// write-through to memory in progress
		WriteDone	// write finished, waiting for CpuReq to fall
	} seqStateT;

endpackage

`default_nettype wire

// ==== tagValidStore.sv ====
////////////////////////////////////////////////////////////
// tag and valid arrays of the cache, one entry per line
// the entry at LookupIndex is registered every cycle, so Hit
// is valid one cycle after the index is presented
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "cache_config.svh"

module tagValidStore import cachePkg::*;
(
	input  logic	Clock,
	input  logic	Reset_L,
	input  indexT	LookupIndex,	// line to look up, from the CPU address
	input  tagT	LookupTag,	// tag to compare against, from the CPU address
	output logic	Hit,		// registered line is valid and its tag matches
	input  indexT	WriteIndex,	// line to update
	input  logic	TagWe,		// store WriteTag at WriteIndex
	input  tagT	WriteTag,
	input  logic	ValidWe,	// store WriteValid at WriteIndex
	input  logic	WriteValid
);

	tagT	tagArray [`CACHE_LINES];	// one tag per line
	logic	validArray [`CACHE_LINES];	// one valid bit per line

	tagT	storedTag;			// tag read at the last edge
	tagT	lookupTagQ;			// CPU tag registered alongside it
	logic	storedValid;			// valid bit read at the last edge

	////////////////////////////////////////////////////////////
	// array updates
	always_ff @(posedge Clock)
	begin
		if (TagWe)
			tagArray[WriteIndex] <= WriteTag;	// miss claims the line for the new tag
		if (ValidWe)
			validArray[WriteIndex] <= WriteValid;	// invalidate on flush and on writes
	end

	////////////////////////////////////////////////////////////
	// registered lookup, reads the value from before any write at this edge
	always_ff @(posedge Clock)
	begin
		storedTag <= tagArray[LookupIndex];
		lookupTagQ <= LookupTag;			// keeps the compare aligned with the read
	end

	always_ff @(posedge Clock, negedge Reset_L)
	begin
		if (!Reset_L)
			storedValid <= 1'b0;			// no hit can be reported straight out of reset
		else
			storedValid <= validArray[LookupIndex];
	end

	// compare lives here so the sequencer only sees a single hit bit
	assign Hit = storedValid && (storedTag == lookupTagQ);

endmodule

`default_nettype wire

// ==== lineDataStore.sv ====
////////////////////////////////////////////////////////////
// data array of the cache, eight words per line
// writes land on the clock edge and honour the byte lanes
// the read port is combinational and feeds the CPU directly
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "cache_config.svh"

module lineDataStore import cachePkg::*;
(
	input  logic	Clock,
	input  indexT	WriteIndex,	// line being filled
	input  wordSelT	WriteWordSel,	// word inside that line
	input  logic	We,
	input  dataT	WriteData,
	input  byteEnT	WriteByteEn,	// bit 1 upper byte, bit 0 lower byte
	input  indexT	ReadIndex,
	input  wordSelT	ReadWordSel,
	output dataT	ReadData
);

	localparam int ByteW = `CACHE_DATA_W / 2;	// width of one byte lane

	dataT dataArray [`CACHE_LINES * `CACHE_LINE_WORDS];	// line index above word select

	logic [`CACHE_INDEX_W+`CACHE_WORD_SEL_W-1:0] writeAddr;	// flat word address
	logic [`CACHE_INDEX_W+`CACHE_WORD_SEL_W-1:0] readAddr;

	assign writeAddr = {WriteIndex, WriteWordSel};
	assign readAddr = {ReadIndex, ReadWordSel};

	always_ff @(posedge Clock)
	begin
		if (We && WriteByteEn[1])
			dataArray[writeAddr][`CACHE_DATA_W-1 -: ByteW] <= WriteData[`CACHE_DATA_W-1 -: ByteW];
		if (We && WriteByteEn[0])
			dataArray[writeAddr][ByteW-1:0] <= WriteData[ByteW-1:0];	// lower lane
	end

	assign ReadData = dataArray[readAddr];	// word at the CPU address, no wait state

endmodule

`default_nettype wire

// ==== memBusMaster.sv ====
////////////////////////////////////////////////////////////
// memory side four-phase req/ack master
// a one cycle Start latches Request and runs one word
// handshake, WordDone pulses when MemAck is seen and Busy
// stays high until memory has dropped MemAck again
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module memBusMaster import cachePkg::*;
(
	input  logic	Clock,
	input  logic	Reset_L,
	input  logic	Start,		// one cycle pulse, only honoured while idle
	input  memReqT	Request,	// address, data and lanes for this word
	output logic	Busy,		// a handshake is open on the memory bus
	output logic	WordDone,	// MemAck seen, MemReadData valid this cycle
	output logic	MemReq,
	output memReqT	Mem,
	input  logic	MemAck
);

	typedef enum logic [1:0] {
		BusIdle,	// no handshake open
		BusRequest,	// MemReq high, waiting for MemAck
		BusRelease	// MemReq low, waiting for MemAck to fall
	} busPhaseT;

	busPhaseT	phase;
	memReqT		requestQ;	// request held for the whole handshake

	always_ff @(posedge Clock, negedge Reset_L)
	begin
		if (!Reset_L)
			phase <= BusIdle;
		else
		begin
			case (phase)
			BusIdle:
				if (Start)
					phase <= BusRequest;		// raise MemReq on the next cycle
			BusRequest:
				if (MemAck)
					phase <= BusRelease;		// MemReq drops on this edge
			BusRelease:
				if (!MemAck)
					phase <= BusIdle;		// memory closed its side
			default:
				phase <= BusIdle;
			endcase
		end
	end

	always_ff @(posedge Clock)
	begin
		if (Start && (phase == BusIdle))
			requestQ <= Request;			// keeps Mem stable under MemReq
	end

	assign MemReq = (phase == BusRequest);
	assign Mem = requestQ;
	assign WordDone = (phase == BusRequest) && MemAck;	// same cycle as the read data
	assign Busy = (phase != BusIdle);

endmodule

`default_nettype wire

// ==== cacheSequencer.sv ====
////////////////////////////////////////////////////////////
// control FSM of the write-through read cache
// flushes all lines after reset, answers read hits from the
// data array, burst-fills a line on a read miss and passes
// every CPU write through to memory
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "cache_config.svh"

module cacheSequencer import cachePkg::*;
(
	input  logic	Clock,
	input  logic	Reset_L,
	input  logic	CpuReq,		// four-phase request from the CPU
	input  cpuReqT	Cpu,		// held stable while CpuReq is high
	output logic	CpuAck,		// registered acknowledge back to the CPU
	input  logic	Hit,		// from the tag store, valid in Lookup
	output logic	TagWe,
	output logic	ValidWe,
	output logic	WriteValid,
	output indexT	WriteIndex,	// line written in the tag, valid and data arrays
	output logic	DataWe,
	output wordSelT	FillWordSel,	// word of the line being filled
	output logic	MemStart,
	output memReqT	MemRequest,
	input  logic	MemBusy,
	input  logic	WordDone
);

	seqStateT	state;
	seqStateT	nextState;
	indexT		lineCount;	// line during flush, word during fill

	tagT		cpuTag;		// fields of the CPU address
	indexT		cpuIndex;

	assign cpuTag = Cpu.address[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
	assign cpuIndex = Cpu.address[`CACHE_WORD_SEL_W+1 +: `CACHE_INDEX_W];

	////////////////////////////////////////////////////////////
	// state, counter and acknowledge registers
	always_ff @(posedge Clock, negedge Reset_L)
	begin
		if (!Reset_L)
		begin
			state <= Invalidate;			// flush every line first
			lineCount <= '0;
			CpuAck <= 1'b0;
		end
		else
		begin
			state <= nextState;
			if (state == Invalidate)
				lineCount <= lineCount + 1'b1;	// one line per cycle, wraps to 0
			else if (state == Lookup)
				lineCount <= '0;		// a fill always starts at word 0
			else if ((state == Fill) && WordDone)
				lineCount <= lineCount + 1'b1;	// next word of the burst
			// ack rises one edge after the done state is entered and follows CpuReq down
			CpuAck <= ((state == ReadDone) || (state == WriteDone)) && CpuReq;
		end
	end

	////////////////////////////////////////////////////////////
	// next state and array strobes
	always_comb
	begin
		nextState = state;
		TagWe = 1'b0;
		ValidWe = 1'b0;
		WriteValid = 1'b0;
		DataWe = 1'b0;
		case (state)
		Invalidate:
		begin
			ValidWe = 1'b1;				// clear the valid bit of lineCount
			if (lineCount == indexT'(`CACHE_LINES - 1))
				nextState = Idle;
		end
		Idle:
		begin
			if (CpuReq && Cpu.write)
			begin
				ValidWe = 1'b1;			// no write allocate, drop the line
				nextState = WriteMem;
			end
			else if (CpuReq)
				nextState = Lookup;		// tag store samples the index on this edge
		end
		Lookup:
		begin
			if (Hit)
				nextState = ReadDone;
			else
			begin
				TagWe = 1'b1;			// claim the line before the burst
				ValidWe = 1'b1;
				WriteValid = 1'b1;
				nextState = Fill;
			end
		end
		Fill:
		begin
			if (WordDone)
			begin
				DataWe = 1'b1;			// MemReadData is valid with WordDone
				if (lineCount == indexT'(`CACHE_LINE_WORDS - 1))
					nextState = ReadDone;
			end
		end
		WriteMem:
		begin
			if (WordDone)
				nextState = WriteDone;		// memory accepted the write
		end
		ReadDone, WriteDone:
		begin
			if (!CpuReq)
				nextState = Idle;		// CPU closed the handshake
		end
		default:
			nextState = Invalidate;
		endcase
	end

	////////////////////////////////////////////////////////////
	// memory requests
	// a new word starts only once the previous handshake has fully closed
	assign MemStart = ((state == Fill) || (state == WriteMem)) && !MemBusy;

	always_comb
	begin
		if (state == Fill)
		begin
			MemRequest.address = {cpuTag, cpuIndex, FillWordSel, 1'b0};	// aligned line word
			MemRequest.writeData = '0;
			MemRequest.write = 1'b0;
			MemRequest.byteEn = 2'b11;		// fill always reads both bytes
		end
		else
		begin
			MemRequest.address = Cpu.address;	// write goes out exactly as issued
			MemRequest.writeData = Cpu.writeData;
			MemRequest.write = 1'b1;
			MemRequest.byteEn = Cpu.byteEn;
		end
	end

	assign FillWordSel = lineCount[`CACHE_WORD_SEL_W-1:0];
	assign WriteIndex = (state == Invalidate) ? lineCount : cpuIndex;

endmodule

`default_nettype wire

// ==== cacheCtrlTop.sv ====
////////////////////////////////////////////////////////////
// top level of the write-through read cache
// CPU side and memory side are four-phase req/ack buses
// holds only the sequencer, the two stores and the memory
// bus master, plus the address slicing between them
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "cache_config.svh"

module cacheCtrlTop import cachePkg::*;
(
	input  logic	Clock,
	input  logic	Reset_L,
	input  logic	CpuReq,
	input  cpuReqT	Cpu,
	output logic	CpuAck,
	output dataT	CpuReadData,	// valid while CpuAck is high on a read
	output logic	MemReq,
	output memReqT	Mem,
	input  logic	MemAck,
	input  dataT	MemReadData	// valid while MemAck is high on a fill
);

	logic		hit;
	logic		tagWe;
	logic		validWe;
	logic		writeValid;
	indexT		writeIndex;
	logic		dataWe;
	wordSelT	fillWordSel;
	logic		memStart;
	memReqT		memRequest;
	logic		memBusy;
	logic		wordDone;

	tagT		cpuTag;		// CPU address fields for lookup and read port
	indexT		cpuIndex;
	wordSelT	cpuWordSel;

	assign cpuTag = Cpu.address[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
	assign cpuIndex = Cpu.address[`CACHE_WORD_SEL_W+1 +: `CACHE_INDEX_W];
	assign cpuWordSel = Cpu.address[1 +: `CACHE_WORD_SEL_W];	// bit 0 is the byte bit

	cacheSequencer sequencer (
		.Clock(Clock), .Reset_L(Reset_L),
		.CpuReq(CpuReq), .Cpu(Cpu), .CpuAck(CpuAck), .Hit(hit),
		.TagWe(tagWe), .ValidWe(validWe), .WriteValid(writeValid), .WriteIndex(writeIndex),
		.DataWe(dataWe), .FillWordSel(fillWordSel),
		.MemStart(memStart), .MemRequest(memRequest), .MemBusy(memBusy), .WordDone(wordDone)
	);

	tagValidStore tagStore (
		.Clock(Clock), .Reset_L(Reset_L),
		.LookupIndex(cpuIndex), .LookupTag(cpuTag), .Hit(hit),
		.WriteIndex(writeIndex), .TagWe(tagWe), .WriteTag(cpuTag),
		.ValidWe(validWe), .WriteValid(writeValid)
	);

	lineDataStore dataStore (
		.Clock(Clock),
		.WriteIndex(writeIndex), .WriteWordSel(fillWordSel), .We(dataWe),
		.WriteData(MemReadData), .WriteByteEn(byteEnT'(2'b11)),		// fills write whole words
		.ReadIndex(cpuIndex), .ReadWordSel(cpuWordSel), .ReadData(CpuReadData)
	);

	memBusMaster busMaster (
		.Clock(Clock), .Reset_L(Reset_L),
		.Start(memStart), .Request(memRequest), .Busy(memBusy), .WordDone(wordDone),
		.MemReq(MemReq), .Mem(Mem), .MemAck(MemAck)
	);

endmodule

`default_nettype wire

// ==== cacheCtrl_assert.sv ====
////////////////////////////////////////////////////////////
// handshake assertions for the cache controller
// bound into cacheCtrlTop, watches the CPU and memory buses
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module cacheCtrlAssert import cachePkg::*;
(
	input  logic	Clock,
	input  logic	Reset_L,
	input  logic	CpuReq,
	input  logic	CpuAck,
	input  logic	MemReq,
	input  memReqT	Mem,
	input  logic	MemAck
);

	// the edge that raised CpuAck must have seen CpuReq high
	ackNeedsReq: assert property (@(posedge Clock) disable iff (!Reset_L)
		$rose(CpuAck) |-> $past(CpuReq))
		else $error("CpuAck rose while CpuReq was low");

	// address, data and lanes may only change once MemReq has dropped
	memStableUnderReq: assert property (@(posedge Clock) disable iff (!Reset_L)
		(MemReq && $past(MemReq)) |-> $stable(Mem))
		else $error("Mem changed while MemReq was high");

	memReqHeldForAck: assert property (@(posedge Clock) disable iff (!Reset_L)
		$fell(MemReq) |-> $past(MemAck))
		else $error("MemReq fell before MemAck was seen");

endmodule

bind cacheCtrlTop cacheCtrlAssert handshakeChecks (
	.Clock(Clock), .Reset_L(Reset_L), .CpuReq(CpuReq), .CpuAck(CpuAck),
	.MemReq(MemReq), .Mem(Mem), .MemAck(MemAck)
);

`default_nettype wire

// ==== cacheCtrlChecker.sv ====
////////////////////////////////////////////////////////////
// checker of the cache controller testbench
// records every memory handshake of a CPU transfer and
// checks read data, fill order, write-through and hit timing
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "cache_config.svh"

module cacheCtrlChecker import cachePkg::*;
(
	input  logic	Clock,
	input  logic	Reset_L,
	input  logic	CpuReq,
	input  cpuReqT	Cpu,
	input  logic	CpuAck,
	input  dataT	CpuReadData,
	input  logic	MemReq,
	input  memReqT	Mem,
	input  dataT	ExpectedData,	// reference word at the CPU address
	input  logic	ExpectHit,	// reference cache predicts a read hit
	output int	ValueErrors,
	output int	ProtocolErrors
);

	int		cycle;		// counts rising edges
	int		startCycle;	// edge that first sampled CpuReq high
	logic		inFlight;
	logic		seenRequest;
	logic		ackQ;
	logic		memReqQ;
	memReqT		memQ [$];	// memory requests of the current transfer

	task automatic compareValue(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
		begin
			$display("error at %0d ns: %s is %h, expected %h", $time, name, got, expected);
			ValueErrors++;
		end
	endtask

	task automatic protocolError(input string what);
		$display("protocol failure at %0d ns: %s", $time, what);
		ProtocolErrors++;
	endtask

	task automatic checkTransaction();
		addrT lineBase;
		lineBase = {Cpu.address[31:4], 4'h0};		// first byte of the aligned line
		if (Cpu.write)
		begin
			if (memQ.size() != 1)
				protocolError($sformatf("write made %0d memory requests", memQ.size()));
			else
			begin
				compareValue("Mem.write", 32'(memQ[0].write), 32'd1);
				compareValue("Mem.address", memQ[0].address, Cpu.address);
				compareValue("Mem.writeData", 32'(memQ[0].writeData), 32'(Cpu.writeData));
				compareValue("Mem.byteEn", 32'(memQ[0].byteEn), 32'(Cpu.byteEn));
			end
		end
		else
		begin
			compareValue("CpuReadData", 32'(CpuReadData), 32'(ExpectedData));
			if (ExpectHit && (memQ.size() != 0))
				protocolError("read hit went out to memory");
			else if (ExpectHit && ((cycle - 1) - startCycle != 2))
				protocolError("read hit CpuAck did not rise two edges after CpuReq");
			else if (!ExpectHit && (memQ.size() != `CACHE_LINE_WORDS))
				protocolError($sformatf("read miss made %0d memory requests", memQ.size()));
			else if (!ExpectHit)
			begin
				foreach (memQ[i])
				begin
					compareValue("Mem.address", memQ[i].address, lineBase + 32'(2 * i));
					compareValue("Mem.write", 32'(memQ[i].write), 32'd0);
					compareValue("Mem.byteEn", 32'(memQ[i].byteEn), 32'd3);
				end
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// sampled on the edge, inputs move 1 ns later
	always @(posedge Clock)
	begin
		cycle++;
		if (!Reset_L)
		begin
			inFlight = 1'b0;
			seenRequest = 1'b0;
			ackQ = 1'b0;
			memReqQ = 1'b0;
			ValueErrors = 0;
			ProtocolErrors = 0;
		end
		else
		begin
			if (!seenRequest && (CpuAck || MemReq))
				protocolError("CpuAck or MemReq went high before any CPU request");
			if (CpuReq && !inFlight)
			begin
				inFlight = 1'b1;			// new transfer opens
				seenRequest = 1'b1;
				startCycle = cycle;
				memQ.delete();
			end
			if (MemReq && !memReqQ)
				memQ.push_back(Mem);			// one entry per MemReq rise
			if (CpuAck && !ackQ)
				checkTransaction();			// ack rose on the previous edge
			if (!CpuReq)
				inFlight = 1'b0;
			ackQ = CpuAck;
			memReqQ = MemReq;
		end
	end

endmodule

`default_nettype wire

// ==== cacheCtrlTb.sv ====
////////////////////////////////////////////////////////////
// testbench top of the write-through read cache
// drives CPU transfers, models memory with a random MemAck
// delay and keeps the reference memory and tag state
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "cache_config.svh"

module cacheCtrlTb import cachePkg::*;
();

	localparam int NumTransactions = 316;		// 1 + 1 + 8 + 6 + 300 CPU transfers
	localparam int WatchdogCycles = NumTransactions * 60 + 100;

	logic		Clock;
	logic		Reset_L;
	logic		CpuReq;
	cpuReqT		Cpu;
	logic		CpuAck;
	dataT		CpuReadData;
	logic		MemReq;
	memReqT		Mem;
	logic		MemAck;
	dataT		MemReadData;
	dataT		expectedData;
	logic		expectHit;
	int		valueErrors;
	int		protocolErrors;
	int		ackDelay;		// cycles the memory model still waits

	dataT		memWords [addrT];	// memory model content by word address
	dataT		shadowWords [addrT];	// reference copy, written from the CPU side
	tagT		refTag [`CACHE_LINES];
	logic		refValid [`CACHE_LINES];

	cacheCtrlTop DUT (.*);

	cacheCtrlChecker monitor (
		.Clock(Clock), .Reset_L(Reset_L), .CpuReq(CpuReq), .Cpu(Cpu), .CpuAck(CpuAck),
		.CpuReadData(CpuReadData), .MemReq(MemReq), .Mem(Mem),
		.ExpectedData(expectedData), .ExpectHit(expectHit),
		.ValueErrors(valueErrors), .ProtocolErrors(protocolErrors)
	);

	initial
	begin
		Clock = 1'b0;
		forever #4 Clock = ~Clock;
	end

	// power-up content, different for every word address
	function automatic dataT initialWord(input addrT wordAddr);
		return wordAddr[15:0] ^ wordAddr[31:16];
	endfunction

	function automatic dataT mergeBytes(input dataT oldWord, input dataT newWord, input byteEnT byteEn);
		dataT merged;
		merged = oldWord;
		if (byteEn[1])
			merged[15:8] = newWord[15:8];
		if (byteEn[0])
			merged[7:0] = newWord[7:0];
		return merged;
	endfunction

	function automatic dataT expectedRead(input addrT address);
		addrT wordAddr;
		wordAddr = address >> 1;
		if (shadowWords.exists(wordAddr))
			return shadowWords[wordAddr];
		return initialWord(wordAddr);
	endfunction

	////////////////////////////////////////////////////////////
	// memory model, answers each MemReq after 0 to 3 cycles
	initial
	begin
		addrT wordAddr;
		MemAck = 1'b0;
		MemReadData = '0;
		ackDelay = 0;
		forever
		begin
			@(posedge Clock);
			#1;
			if (MemReq && !MemAck && (ackDelay > 0))
				ackDelay--;
			else if (MemReq && !MemAck)
			begin
				wordAddr = Mem.address >> 1;
				if (!memWords.exists(wordAddr))
					memWords[wordAddr] = initialWord(wordAddr);
				if (Mem.write)
					memWords[wordAddr] = mergeBytes(memWords[wordAddr], Mem.writeData, Mem.byteEn);
				else
					MemReadData = memWords[wordAddr];
				MemAck = 1'b1;
				ackDelay = $urandom_range(3, 0);	// delay of the next handshake
			end
			else if (!MemReq && MemAck)
				MemAck = 1'b0;				// master closed its side
		end
	end

	task automatic waitForAck(input logic level);
		do
		begin
			@(posedge Clock);
			#1;
		end
		while (CpuAck != level);
	endtask

	// one four-phase CPU transfer, the reference state moves with it
	task automatic cpuTransfer(input addrT address, input logic write, input dataT writeData,
		input byteEnT byteEn);
		indexT index;
		tagT tag;
		index = address[8:4];
		tag = address[31:9];
		expectedData = expectedRead(address);
		expectHit = refValid[index] && (refTag[index] == tag);
		if (write)
		begin
			shadowWords[address >> 1] = mergeBytes(expectedRead(address), writeData, byteEn);
			refValid[index] = 1'b0;			// every write drops the indexed line
		end
		else
		begin
			refValid[index] = 1'b1;			// a miss fills, a hit keeps the line
			refTag[index] = tag;
		end
		Cpu.address = address;
		Cpu.writeData = writeData;
		Cpu.write = write;
		Cpu.byteEn = byteEn;
		CpuReq = 1'b1;
		waitForAck(1'b1);
		CpuReq = 1'b0;
		waitForAck(1'b0);
	endtask

	task automatic finishRun(input logic timedOut);
		$display("errors: %0d value, %0d protocol, %0d timeout", valueErrors, protocolErrors,
			timedOut);
		if ((valueErrors == 0) && (protocolErrors == 0) && !timedOut)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	endtask

	////////////////////////////////////////////////////////////
	// stimulus
	initial
	begin
		addrT address;
		logic [31:0] rnd;
		void'($urandom(32'ha696_d2e8));
		Reset_L = 1'b0;
		CpuReq = 1'b0;
		Cpu = '0;
		expectedData = '0;
		expectHit = 1'b0;
		for (int i = 0; i < `CACHE_LINES; i++)
			refValid[i] = 1'b0;
		repeat (2) @(posedge Clock);
		#1;
		Reset_L = 1'b1;
		repeat (10) @(posedge Clock);			// first request lands during the flush
		#1;
		cpuTransfer(32'h0000_0126, 1'b0, '0, 2'b11);	// cold miss fills line 18
		cpuTransfer(32'h0000_012c, 1'b0, '0, 2'b11);	// same line, hit
		for (int be = 0; be < 4; be++)
		begin
			rnd = $urandom;
			cpuTransfer(32'h0000_0344, 1'b1, rnd[15:0], byteEnT'(be));
			cpuTransfer(32'h0000_0344, 1'b0, '0, 2'b11);
		end
		for (int i = 0; i < 6; i++)			// both addresses map to line 5
			cpuTransfer(i[0] ? 32'h0002_0258 : 32'h0001_0250, 1'b0, '0, 2'b11);
		for (int i = 0; i < 300; i++)
		begin
			rnd = $urandom;
			address = 32'h0000_4000 | {20'h0, rnd[11:1], 1'b0};	// 4 KB window
			cpuTransfer(address, rnd[31:30] == 2'b00, rnd[29:14], rnd[13:12]);
		end
		repeat (4) @(posedge Clock);
		finishRun(1'b0);
	end

	initial
	begin
		repeat (WatchdogCycles) @(posedge Clock);
		$display("timeout: run did not finish within %0d clock cycles", WatchdogCycles);
		finishRun(1'b1);
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+.
cachePkg.sv
tagValidStore.sv
lineDataStore.sv
memBusMaster.sv
cacheSequencer.sv
cacheCtrlTop.sv
cacheCtrl_assert.sv
cacheCtrlChecker.sv
cacheCtrlTb.sv

// ==== run.sh ====
#!/bin/sh
# builds the cache controller testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module cacheCtrlTb
output=$(./obj_dir/VcacheCtrlTb)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx 'TEST PASS'; then
	exit 0
fi
exit 1
